//--- hdl/alu_pkg.sv
package alu_pkg;

    // width of every data word in the machine
    localparam int word_w = 16;

    // one data word
    // acc, mbr, pc and memory words all use this
    typedef logic [word_w-1:0] word_t;

    // alu operation codes
    // one code per alu case
    typedef enum logic [3:0] {
        // arithmetic
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_mul  = 4'h2,
        alu_div  = 4'h3,
        // single bit moves on operand1
        alu_shl  = 4'h4,
        alu_shr  = 4'h5,
        alu_rol  = 4'h6,
        alu_ror  = 4'h7,
        // bitwise logic
        alu_and  = 4'h8,
        alu_or   = 4'h9,
        alu_xor  = 4'ha,
        alu_nor  = 4'hb,
        alu_nand = 4'hc,
        alu_xnor = 4'hd,
        // compares give 1 or 0
        alu_gt   = 4'he,
        alu_eq   = 4'hf
    } alu_op_t;

endpackage

//--- hdl/isa_pkg.sv
package isa_pkg;

    // instruction field widths
    localparam int opcode_w = 4;
    localparam int addr_field_w = 12;
    localparam int imm_w = 8;

    // main opcodes
    // codes 0 and a..f are not listed and act as no-operation
    typedef enum logic [opcode_w-1:0] {
        // acc <= mem[addr]
        op_lda  = 4'h1,
        // mem[addr] <= acc
        op_sta  = 4'h2,
        // acc <= acc + mem[addr]
        op_add  = 4'h3,
        // acc <= acc - mem[addr]
        op_sub  = 4'h4,
        // pc <= addr
        op_jmp  = 4'h5,
        // pc <= addr when acc is zero
        op_jz   = 4'h6,
        // acc <= acc alu_op imm
        op_alui = 4'h7,
        // acc onto the output strobe
        op_out  = 4'h8,
        // stop until the next start
        op_hlt  = 4'h9
    } opcode_t;

    // memory reference view
    // opcode on top, 12 bit address below
    typedef struct packed {
        opcode_t                 opcode;
        logic [addr_field_w-1:0] addr;
    } mem_form_t;

    // operate view
    // alu_op sits where the top of the address would be
    typedef struct packed {
        opcode_t            opcode;
        alu_pkg::alu_op_t   alu_op;
        logic [imm_w-1:0]   imm;
    } op_form_t;

    // one instruction word
    // both views overlay the same 16 bits
    typedef union packed {
        mem_form_t mem_form;
        op_form_t  op_form;
    } instr_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  alu_pkg::alu_op_t opcode,
    input  alu_pkg::word_t   operand1,
    input  alu_pkg::word_t   operand2,
    output alu_pkg::word_t   result
);
    import alu_pkg::*;

    // divider guard
    logic div_by_zero;

    assign div_by_zero = (operand2 == '0);

    always_comb begin
        case (opcode)
            alu_add:  result = operand1 + operand2;
            alu_sub:  result = operand1 - operand2;
            // product keeps the low word only
            alu_mul:  result = operand1 * operand2;
            // zero divisor gives all ones
            alu_div:  result = div_by_zero ? '1 : operand1 / operand2;
            // shifts ignore operand2
            alu_shl:  result = operand1 << 1;
            alu_shr:  result = operand1 >> 1;
            // rotates wrap the end bit around
            alu_rol:  result = {operand1[word_w-2:0], operand1[word_w-1]};
            alu_ror:  result = {operand1[0], operand1[word_w-1:1]};
            alu_and:  result = operand1 & operand2;
            alu_or:   result = operand1 | operand2;
            alu_xor:  result = operand1 ^ operand2;
            alu_nor:  result = ~(operand1 | operand2);
            alu_nand: result = ~(operand1 & operand2);
            alu_xnor: result = ~(operand1 ^ operand2);
            // unsigned compare
            alu_gt:   result = (operand1 > operand2) ? word_t'(1) : '0;
            alu_eq:   result = (operand1 == operand2) ? word_t'(1) : '0;
            default:  result = '0;
        endcase
    end

endmodule

//--- hdl/main_memory.sv
`timescale 1ns/1ps

module main_memory #(
    parameter int addr_w = 8
) (
    input  logic              clk,
    // cpu port
    input  logic [addr_w-1:0] addr,
    input  alu_pkg::word_t    wdata,
    input  logic              we,
    // host load port
    input  logic              prog_we,
    input  logic [addr_w-1:0] prog_addr,
    input  alu_pkg::word_t    prog_data,
    output alu_pkg::word_t    rdata
);
    import alu_pkg::*;

    localparam int depth = 2 ** addr_w;

    // word array
    word_t mem [depth];

    // one access per edge
    // host write beats cpu write beats read
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end else if (we) begin
            mem[addr] <= wdata;
        end else begin
            // read data valid the cycle after addr
            rdata <= mem[addr];
        end
    end

    // rdata holds its last value on write cycles
    // control never samples it right after a write

endmodule

//--- hdl/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter int addr_w = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    // register enables from control
    input  logic              pc_load,
    input  logic              pc_inc,
    input  logic              mar_from_pc,
    input  logic              mar_from_ir,
    input  logic              mbr_load,
    input  logic              ir_load,
    input  logic              acc_load,
    input  logic              acc_from_mem,
    input  logic              mem_we,
    // data coming back
    input  alu_pkg::word_t    mem_rdata,
    input  alu_pkg::word_t    alu_result,
    // memory side
    output logic [addr_w-1:0] mem_addr,
    output alu_pkg::word_t    mem_wdata,
    // alu side
    output alu_pkg::word_t    alu_a,
    output alu_pkg::word_t    alu_b,
    output alu_pkg::alu_op_t  alu_sel,
    // state seen by control and the top
    output isa_pkg::instr_t   ir,
    output alu_pkg::word_t    acc,
    output alu_pkg::word_t    pc,
    output logic              acc_zero
);
    import alu_pkg::*;
    import isa_pkg::*;

    logic [addr_w-1:0] mar;
    word_t             mbr;
    // word on its way into mbr
    word_t             mbr_fwd;
    word_t             jump_target;

    // address field zero extended to a full pc
    assign jump_target = word_t'(ir.mem_form.addr);

    // bypass so a word read this cycle reaches acc and the alu
    assign mbr_fwd = mbr_load ? mem_rdata : mbr;

    // program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= jump_target;
        end else if (pc_inc) begin
            pc <= pc + word_t'(1);
        end
    end

    // memory address register
    // upper address bits dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (mar_from_ir) begin
            mar <= ir.mem_form.addr[addr_w-1:0];
        end else if (mar_from_pc) begin
            mar <= pc[addr_w-1:0];
        end
    end

    // mbr takes read words, or mirrors acc on a store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mbr <= '0;
        end else if (mbr_load) begin
            mbr <= mem_rdata;
        end else if (mem_we) begin
            mbr <= acc;
        end
    end

    // instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= mem_rdata;
        end
    end

    // accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (start) begin
            acc <= '0;
        end else if (acc_load) begin
            acc <= acc_from_mem ? mbr_fwd : alu_result;
        end
    end

    // operand and op select by opcode
    always_comb begin
        case (ir.op_form.opcode)
            // immediate path reads the operate view
            op_alui: begin
                alu_sel = ir.op_form.alu_op;
                alu_b   = word_t'(ir.op_form.imm);
            end
            op_sub: begin
                alu_sel = alu_sub;
                alu_b   = mbr_fwd;
            end
            default: begin
                alu_sel = alu_add;
                alu_b   = mbr_fwd;
            end
        endcase
    end

    assign alu_a     = acc;
    assign mem_addr  = mar;
    assign mem_wdata = acc;
    assign acc_zero  = (acc == '0);

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  isa_pkg::instr_t ir,
    input  logic            acc_zero,
    // datapath enables
    output logic            pc_load,
    output logic            pc_inc,
    output logic            mar_from_pc,
    output logic            mar_from_ir,
    output logic            mbr_load,
    output logic            ir_load,
    output logic            acc_load,
    output logic            acc_from_mem,
    output logic            mem_we,
    // status
    output logic            out_valid,
    output logic            halted
);
    import isa_pkg::*;

    // fsm state codes
    localparam logic [2:0] idle       = 3'd0;
    localparam logic [2:0] fetch_addr = 3'd1;
    localparam logic [2:0] fetch_read = 3'd2;
    localparam logic [2:0] decode     = 3'd3;
    localparam logic [2:0] exec_addr  = 3'd4;
    localparam logic [2:0] exec_read  = 3'd5;
    localparam logic [2:0] exec_write = 3'd6;
    localparam logic [2:0] halt       = 3'd7;

    logic [2:0] state;
    logic [2:0] next_state;
    opcode_t    opcode;

    // opcode bits sit in the same place in both views
    assign opcode = ir.mem_form.opcode;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        pc_load      = 1'b0;
        pc_inc       = 1'b0;
        mar_from_pc  = 1'b0;
        mar_from_ir  = 1'b0;
        mbr_load     = 1'b0;
        ir_load      = 1'b0;
        acc_load     = 1'b0;
        acc_from_mem = 1'b0;
        mem_we       = 1'b0;
        out_valid    = 1'b0;
        next_state   = state;
        case (state)
            // address of the next instruction
            fetch_addr: begin
                mar_from_pc = 1'b1;
                next_state  = fetch_read;
            end
            // memory read cycle
            fetch_read: next_state = decode;
            // instruction word arrives
            decode: begin
                mbr_load   = 1'b1;
                ir_load    = 1'b1;
                pc_inc     = 1'b1;
                next_state = exec_addr;
            end
            // first execute cycle
            // single cycle ops finish here
            exec_addr: begin
                next_state = fetch_addr;
                case (opcode)
                    op_lda, op_add, op_sub: begin
                        mar_from_ir = 1'b1;
                        next_state  = exec_read;
                    end
                    op_sta: begin
                        mar_from_ir = 1'b1;
                        next_state  = exec_write;
                    end
                    op_jmp:  pc_load = 1'b1;
                    op_jz:   pc_load = acc_zero;
                    op_alui: acc_load = 1'b1;
                    op_out:  out_valid = 1'b1;
                    op_hlt:  next_state = halt;
                    // unused codes fall through as nop
                    default: next_state = fetch_addr;
                endcase
            end
            // operand read
            exec_read: next_state = exec_write;
            // write back
            // memory for a store, acc for the rest
            exec_write: begin
                if (opcode == op_sta) begin
                    mem_we = 1'b1;
                end else begin
                    mbr_load     = 1'b1;
                    acc_load     = 1'b1;
                    acc_from_mem = (opcode == op_lda);
                end
                next_state = fetch_addr;
            end
            // idle and halt wait for start
            default: next_state = state;
        endcase
        // start always restarts at address 0
        if (start) begin
            next_state = fetch_addr;
        end
    end

    assign halted = (state == halt);

endmodule

//--- hdl/computer.sv
`timescale 1ns/1ps

module computer #(
    parameter int addr_w = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    // host program load
    input  logic              prog_we,
    input  logic [addr_w-1:0] prog_addr,
    input  alu_pkg::word_t    prog_data,
    // status and output strobe
    output logic              halted,
    output logic              out_valid,
    output alu_pkg::word_t    out_data,
    output alu_pkg::word_t    acc,
    output alu_pkg::word_t    pc
);
    import alu_pkg::*;
    import isa_pkg::*;

    // control to datapath enables
    logic pc_load;
    logic pc_inc;
    logic mar_from_pc;
    logic mar_from_ir;
    logic mbr_load;
    logic ir_load;
    logic acc_load;
    logic acc_from_mem;
    logic mem_we;

    // datapath back to control
    instr_t ir;
    logic   acc_zero;

    // memory wires
    logic [addr_w-1:0] mem_addr;
    word_t             mem_wdata;
    word_t             mem_rdata;

    // alu wires
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    alu_op_t alu_sel;

    // strobe data is acc itself
    assign out_data = acc;

    control_unit control_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .ir           (ir),
        .acc_zero     (acc_zero),
        .pc_load      (pc_load),
        .pc_inc       (pc_inc),
        .mar_from_pc  (mar_from_pc),
        .mar_from_ir  (mar_from_ir),
        .mbr_load     (mbr_load),
        .ir_load      (ir_load),
        .acc_load     (acc_load),
        .acc_from_mem (acc_from_mem),
        .mem_we       (mem_we),
        .out_valid    (out_valid),
        .halted       (halted)
    );

    datapath #(
        .addr_w (addr_w)
    ) datapath_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .pc_load      (pc_load),
        .pc_inc       (pc_inc),
        .mar_from_pc  (mar_from_pc),
        .mar_from_ir  (mar_from_ir),
        .mbr_load     (mbr_load),
        .ir_load      (ir_load),
        .acc_load     (acc_load),
        .acc_from_mem (acc_from_mem),
        .mem_we       (mem_we),
        .mem_rdata    (mem_rdata),
        .alu_result   (alu_result),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_sel      (alu_sel),
        .ir           (ir),
        .acc          (acc),
        .pc           (pc),
        .acc_zero     (acc_zero)
    );

    alu alu_inst (
        .opcode   (alu_sel),
        .operand1 (alu_a),
        .operand2 (alu_b),
        .result   (alu_result)
    );

    main_memory #(
        .addr_w (addr_w)
    ) main_memory_inst (
        .clk       (clk),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .we        (mem_we),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rdata     (mem_rdata)
    );

endmodule

//--- tests/tb_ref_model.svh
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// one alu step at word level
function automatic word_t apply_alu(input alu_op_t op, input word_t a, input word_t b);
    word_t r;
    case (op)
        alu_add:  r = a + b;
        alu_sub:  r = a - b;
        alu_mul:  r = a * b;
        // zero divisor is defined as all ones
        alu_div:  r = (b == '0) ? {word_w{1'b1}} : a / b;
        alu_shl:  r = {a[word_w-2:0], 1'b0};
        alu_shr:  r = {1'b0, a[word_w-1:1]};
        alu_rol:  r = (a << 1) | (a >> (word_w - 1));
        alu_ror:  r = (a >> 1) | (a << (word_w - 1));
        alu_and:  r = a & b;
        alu_or:   r = a | b;
        alu_xor:  r = a ^ b;
        alu_nor:  r = ~(a | b);
        alu_nand: r = ~(a & b);
        alu_xnor: r = ~(a ^ b);
        alu_gt:   r = (a > b) ? word_t'(1) : word_t'(0);
        default:  r = (a == b) ? word_t'(1) : word_t'(0);
    endcase
    return r;
endfunction

// runs a whole program image at instruction level
// returns 1 when a halt was reached within max_steps
function automatic bit execute_image(
    input  word_t image [mem_depth],
    input  int    max_steps,
    output word_t outs [$],
    output word_t final_acc,
    output word_t final_pc
);
    word_t             mem [mem_depth];
    word_t             acc;
    word_t             pc;
    instr_t            ins;
    logic [addr_w-1:0] ea;
    int                step;
    mem = image;
    acc = '0;
    pc = '0;
    outs = {};
    for (step = 0; step < max_steps; step++) begin
        // fetch from the low address bits only
        ins = mem[pc[addr_w-1:0]];
        pc = pc + word_t'(1);
        ea = ins.mem_form.addr[addr_w-1:0];
        case (ins.mem_form.opcode)
            op_lda:  acc = mem[ea];
            op_sta:  mem[ea] = acc;
            op_add:  acc = acc + mem[ea];
            op_sub:  acc = acc - mem[ea];
            op_jmp:  pc = word_t'(ins.mem_form.addr);
            op_jz: begin
                if (acc == '0) begin
                    pc = word_t'(ins.mem_form.addr);
                end
            end
            op_alui: acc = apply_alu(ins.op_form.alu_op, acc, word_t'(ins.op_form.imm));
            op_out:  outs.push_back(acc);
            op_hlt: begin
                // pc already points past the halt
                final_acc = acc;
                final_pc = pc;
                return 1'b1;
            end
            // everything else leaves state alone
            default: ;
        endcase
    end
    final_acc = acc;
    final_pc = pc;
    return 1'b0;
endfunction

`endif

//--- tests/tb_computer.sv
`timescale 1ns/1ps

module tb_computer;
    import alu_pkg::*;
    import isa_pkg::*;

    localparam int addr_w = 8;
    localparam int mem_depth = 1 << addr_w;
    // data area well above any program
    localparam int data_base = 'hc0;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;
    word_t             prog_data;
    logic              halted;
    logic              out_valid;
    word_t             out_data;
    word_t             acc;
    word_t             pc;

    // program image and its write pointer
    word_t image [mem_depth];
    int    wp;

    // expected out_data words drained by the monitor
    word_t exp_queue [$];
    string test_name;
    int    got_count;

    int checks;
    int value_errors;
    int other_errors;
    int seed;

    `include "tb_ref_model.svh"

    computer #(
        .addr_w (addr_w)
    ) computer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .out_valid (out_valid),
        .out_data  (out_data),
        .acc       (acc),
        .pc        (pc)
    );

    always #10 clk = ~clk;

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", what, expected, actual);
            value_errors++;
        end
    endtask

    function automatic word_t mem_instr(input opcode_t op, input int addr);
        instr_t w;
        w.mem_form.opcode = op;
        w.mem_form.addr = addr[addr_field_w-1:0];
        return word_t'(w);
    endfunction

    function automatic word_t alu_instr(input alu_op_t op, input logic [imm_w-1:0] imm);
        instr_t w;
        w.op_form.opcode = op_alui;
        w.op_form.alu_op = op;
        w.op_form.imm = imm;
        return word_t'(w);
    endfunction

    // unlisted opcode with arbitrary low bits
    function automatic word_t nop_instr(input logic [3:0] code, input int fill);
        return {code, fill[addr_field_w-1:0]};
    endfunction

    task automatic clear_image;
        int i;
        for (i = 0; i < mem_depth; i++) begin
            image[i] = '0;
        end
        wp = 0;
    endtask

    task automatic emit(input word_t w);
        image[wp] = w;
        wp++;
    endtask

    // whole image through the host port
    task automatic load_program;
        int i;
        for (i = 0; i < mem_depth; i++) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= i[addr_w-1:0];
            prog_data <= image[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_program(input string name, input int max_cycles);
        bit    ref_done;
        word_t exp_acc;
        word_t exp_pc;
        int    exp_count;
        int    cycles;
        test_name = name;
        ref_done = execute_image(image, 4000, exp_queue, exp_acc, exp_pc);
        if (!ref_done) begin
            $display("%s: reference model never reached a halt", name);
            other_errors++;
        end
        exp_count = exp_queue.size();
        got_count = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // start clears acc and pc and leaves halt
        @(negedge clk);
        check_flag({name, " halted after start"}, 1'b0, halted);
        check_word({name, " acc after start"}, '0, acc);
        check_word({name, " pc after start"}, '0, pc);
        cycles = 0;
        while (!halted && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: machine did not halt within %0d cycles", name, max_cycles);
            other_errors++;
        end else begin
            check_word({name, " output count"}, word_t'(exp_count), word_t'(got_count));
            check_word({name, " final acc"}, exp_acc, acc);
            check_word({name, " final pc"}, exp_pc, pc);
            // halted is a level until the next start
            repeat (2) @(negedge clk);
            check_flag({name, " halted held"}, 1'b1, halted);
            check_flag({name, " no strobe in halt"}, 1'b0, out_valid);
        end
    endtask

    // compares each strobe against the reference list
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            got_count++;
            if (exp_queue.size() == 0) begin
                $display("%s: out_valid pulsed with no output expected", test_name);
                other_errors++;
            end else begin
                check_word($sformatf("%s out_data #%0d", test_name, got_count),
                           exp_queue.pop_front(), out_data);
            end
        end
    end

    initial begin
        int                i;
        word_t             a;
        word_t             b;
        word_t             c;
        logic [imm_w-1:0]  imm;
        alu_op_t           op;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        got_count = 0;
        test_name = "reset";
        seed = 78;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // idle after reset
        @(negedge clk);
        check_flag("reset halted", 1'b0, halted);
        check_flag("reset out_valid", 1'b0, out_valid);
        check_word("reset acc", '0, acc);
        check_word("reset pc", '0, pc);

        // every alu op on a loaded acc, plus a zero divisor
        clear_image;
        for (i = 0; i < 17; i++) begin
            op = (i < 16) ? alu_op_t'(i[3:0]) : alu_div;
            imm = (i < 16) ? imm_w'($random(seed)) : '0;
            a = word_t'($random(seed));
            if (op == alu_div && i < 16) begin
                imm = imm | 8'h01;
            end
            // compares get an equal pair so gt gives 0 and eq gives 1
            if (op == alu_gt || op == alu_eq) begin
                a = word_t'(imm);
            end
            image[data_base + i] = a;
            emit(mem_instr(op_lda, data_base + i));
            emit(alu_instr(op, imm));
            emit(mem_instr(op_out, 0));
        end
        emit(mem_instr(op_hlt, 0));
        load_program;
        run_program("alu ops", 2000);

        // memory arithmetic and a store round trip
        clear_image;
        a = word_t'($random(seed));
        b = word_t'($random(seed));
        c = word_t'($random(seed));
        image[data_base] = a;
        image[data_base + 1] = b;
        image[data_base + 2] = c;
        emit(mem_instr(op_lda, data_base));
        emit(mem_instr(op_add, data_base + 1));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_sub, data_base + 2));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_sta, data_base + 8));
        emit(alu_instr(alu_and, 8'h00));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_lda, data_base + 8));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_add, data_base + 8));
        emit(mem_instr(op_sta, data_base + 9));
        emit(mem_instr(op_lda, data_base + 9));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_hlt, 0));
        load_program;
        run_program("memory ops", 2000);

        // countdown to zero, then one more word
        clear_image;
        image[data_base] = word_t'(5 + ($random(seed) & 3));
        image[data_base + 1] = word_t'(1);
        emit(mem_instr(op_lda, data_base));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_jz, 5));
        emit(mem_instr(op_sub, data_base + 1));
        emit(mem_instr(op_jmp, 1));
        emit(alu_instr(alu_xor, 8'ha5));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_hlt, 0));
        load_program;
        run_program("countdown", 3000);

        // new program over a halted machine
        clear_image;
        emit(alu_instr(alu_or, imm_w'($random(seed))));
        emit(mem_instr(op_out, 0));
        emit(alu_instr(alu_rol, 8'h00));
        emit(mem_instr(op_out, 0));
        emit(alu_instr(alu_mul, imm_w'($random(seed))));
        emit(mem_instr(op_sta, data_base + 16));
        emit(alu_instr(alu_xnor, 8'h00));
        emit(mem_instr(op_lda, data_base + 16));
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_hlt, 0));
        load_program;
        run_program("restart", 2000);

        // unlisted opcodes leave acc alone
        clear_image;
        image[data_base] = word_t'($random(seed));
        emit(mem_instr(op_lda, data_base));
        emit(nop_instr(4'h0, $random(seed)));
        emit(nop_instr(4'ha, $random(seed)));
        emit(mem_instr(op_out, 0));
        for (i = 'hb; i <= 'hf; i++) begin
            emit(nop_instr(i[3:0], $random(seed)));
        end
        emit(mem_instr(op_out, 0));
        emit(mem_instr(op_hlt, 0));
        load_program;
        run_program("no-ops", 2000);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+tests
hdl/alu_pkg.sv
hdl/isa_pkg.sv
hdl/alu.sv
hdl/main_memory.sv
hdl/datapath.sv
hdl/control_unit.sv
hdl/computer.sv
tests/tb_computer.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_computer -f files.f || exit 1

output="$(./obj_dir/Vtb_computer)"
echo "$output"

echo "$output" | grep -qx "No errors" && exit 0 || exit 1
